// File: hdl/cpu_defs.svh
// ********************************************************************
// Core-wide sizes for the single-cycle MIPS subset.
// WORD_W is fixed at 32 by the jump target and immediate logic.
// DMEM_ADDR_W sets the default data memory depth in words; the word
// index comes from byte address bits [DMEM_ADDR_W+1:2].
// ********************************************************************
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath width
`define WORD_W 32

// Register index width, 32 registers
`define REG_ADDR_W 5

// 16 words of data memory
`define DMEM_ADDR_W 4

// JAL writes its return address here
`define LINK_REG 31

`endif

// File: hdl/cpu_types_pkg.sv
// ********************************************************************
// Encodings shared by the decoder, the datapath and the testbench.
// Only the opcodes and function codes of the supported subset exist.
// ********************************************************************
`default_nettype none

package cpu_types_pkg;

  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDI  = 6'h08,
    ADDIU = 6'h09,
    SLTI  = 6'h0A,
    SLTIU = 6'h0B,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    XORI  = 6'h0E,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    SLLV = 6'h04,
    SRLV = 6'h06,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2A,
    SLTU = 6'h2B
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  typedef enum logic [1:0] {JMP_NONE = 2'b00, JMP_TARGET = 2'b01, JMP_REG = 2'b10} jump_t;

  // Write-back source
  typedef enum logic [1:0] {WB_MEM = 2'b00, WB_ALU = 2'b01, WB_LINK = 2'b10} wbsel_t;

  // Immediate extension, EXT_UPPER fills the low half with zeros
  typedef enum logic [1:0] {EXT_ZERO = 2'b00, EXT_SIGN = 2'b01, EXT_UPPER = 2'b10} ext_t;

endpackage

`default_nettype wire

// File: hdl/control_unit.sv
// ********************************************************************
// Pure combinational decode, no clock.
// Undefined opcodes decode as an ALU_ADD with register write enabled,
// so the fetch side must only issue words of the supported subset.
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

module control_unit
  import cpu_types_pkg::*;
(
  input  opcode_t instr_op,
  input  funct_t  funct_op,
  output aluop_t  alu_op,
  output logic    halt,
  output logic    reg_dst,
  output logic    alu_src,
  output jump_t   jump,
  output logic    branch,
  output logic    mem_read,
  output logic    mem_write,
  output wbsel_t  mem_to_reg,
  output logic    reg_write,
  output ext_t    ext_type,
  output logic    jal
);

  logic is_jr;

  assign is_jr = (instr_op == RTYPE) && (funct_op == JR);

  // ALU operation
  always_comb begin
    alu_op = ALU_ADD;
    halt   = 1'b0;
    case (instr_op)
      RTYPE: begin
        case (funct_op)
          SLLV:       alu_op = ALU_SLL;
          SRLV:       alu_op = ALU_SRL;
          ADD, ADDU:  alu_op = ALU_ADD;
          SUB, SUBU:  alu_op = ALU_SUB;
          AND:        alu_op = ALU_AND;
          OR:         alu_op = ALU_OR;
          XOR:        alu_op = ALU_XOR;
          NOR:        alu_op = ALU_NOR;
          SLT:        alu_op = ALU_SLT;
          SLTU:       alu_op = ALU_SLTU;
          default:    alu_op = ALU_ADD; // JR passes rs through unused
        endcase
      end
      BEQ, BNE:    alu_op = ALU_SUB;    // Equality via zero flag
      SLTI:        alu_op = ALU_SLT;
      SLTIU:       alu_op = ALU_SLTU;
      ANDI:        alu_op = ALU_AND;
      ORI:         alu_op = ALU_OR;
      XORI:        alu_op = ALU_XOR;
      LUI:         alu_op = ALU_OR;     // Extender already shifted the immediate up
      HALT:        halt   = 1'b1;
      default:     alu_op = ALU_ADD;    // ADDI, ADDIU, LW, SW address add
    endcase
  end

  // Datapath steering
  always_comb begin
    reg_dst = (instr_op == RTYPE);     // rd for R-type, rt otherwise
    jal     = (instr_op == JAL);
    branch  = (instr_op == BEQ) || (instr_op == BNE);

    // Second operand from the register file for these
    alu_src = !((instr_op == RTYPE) || (instr_op == J) || (instr_op == JAL) ||
                branch || (instr_op == HALT));

    if ((instr_op == J) || (instr_op == JAL)) begin
      jump = JMP_TARGET;
    end else if (is_jr) begin
      jump = JMP_REG;
    end else begin
      jump = JMP_NONE;
    end

    mem_read  = (instr_op == LW);
    mem_write = (instr_op == SW);

    if (mem_read) begin
      mem_to_reg = WB_MEM;
    end else if (jal) begin
      mem_to_reg = WB_LINK;            // Return address
    end else begin
      mem_to_reg = WB_ALU;
    end

    reg_write = !(is_jr || (instr_op == J) || mem_write || branch || (instr_op == HALT));

    if (instr_op == LUI) begin
      ext_type = EXT_UPPER;
    end else if ((instr_op == ANDI) || (instr_op == ORI) || (instr_op == XORI)) begin
      ext_type = EXT_ZERO;             // Logical immediates
    end else begin
      ext_type = EXT_SIGN;
    end
  end

endmodule

`default_nettype wire

// File: hdl/alu.sv
// ********************************************************************
// Combinational ALU. No overflow detection, add and subtract wrap.
// Shift amount is the low bits of a, the shifted value is b.
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module alu
  import cpu_types_pkg::*;
(
  input  aluop_t             op,
  input  logic [`WORD_W-1:0] a,
  input  logic [`WORD_W-1:0] b,
  output logic [`WORD_W-1:0] result,
  output logic               zero
);

  localparam int sh_w = $clog2(`WORD_W);

  logic [sh_w-1:0] shamt;

  assign shamt = a[sh_w-1:0];

  always_comb begin
    case (op)
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;   // Logical shift
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_NOR:  result = ~(a | b);
      ALU_SLT:  result = {{(`WORD_W-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_SLTU: result = {{(`WORD_W-1){1'b0}}, (a < b)};
      default:  result = '0;
    endcase
  end

  // Branch compare
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/register_file.sv
// ********************************************************************
// Two combinational read ports, one write port on the rising edge.
// A read of the register being written returns the old value.
// Register 0 always reads zero.
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module register_file (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] waddr,
  input  logic [`WORD_W-1:0]     wdata,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  output logic [`WORD_W-1:0]     rdata1,
  output logic [`WORD_W-1:0]     rdata2
);

  localparam int n_regs = 1 << `REG_ADDR_W;

  logic [`WORD_W-1:0] regs [n_regs];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;           // r0 stays zero
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/word_ram.sv
// ********************************************************************
// Word-wide data memory, 2**addr_w entries.
// Combinational read, write on the rising edge, cleared by reset.
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module word_ram #(
  parameter int addr_w = `DMEM_ADDR_W
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               we,
  input  logic [addr_w-1:0]  addr,
  input  logic [`WORD_W-1:0] wdata,
  output logic [`WORD_W-1:0] rdata
);

  localparam int depth = 1 << addr_w;

  logic [`WORD_W-1:0] mem [depth];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
// ********************************************************************
// Single-cycle core, one instruction commits per instr_valid edge.
// No back-pressure; the fetch side must present the word at pc.
// Data addresses wrap on bits [dmem_addr_w+1:2], low two bits ignored.
// Strobes after HALT are dropped until reset.
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core
  import cpu_types_pkg::*;
#(
  parameter int dmem_addr_w = `DMEM_ADDR_W
) (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  input  logic [31:0]            instr,
  output logic [`WORD_W-1:0]     pc,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_reg,
  output logic [`WORD_W-1:0]     wb_data,
  output logic                   mem_write_valid,
  output logic [`WORD_W-1:0]     mem_addr,
  output logic [`WORD_W-1:0]     mem_wdata,
  output logic                   halted
);

  opcode_t instr_op;
  funct_t  funct_op;
  aluop_t  alu_op;
  jump_t   jump;
  wbsel_t  mem_to_reg;
  ext_t    ext_type;
  logic    halt, reg_dst, alu_src, branch, mem_read, mem_write, reg_write, jal;

  logic [`REG_ADDR_W-1:0] rs, rt, rd, waddr;
  logic [`WORD_W-1:0]     rdata1, rdata2, imm_ext, alu_b, alu_result;
  logic [`WORD_W-1:0]     ram_rdata, wdata, pc_plus4, pc_next;
  logic                   zero, commit, taken;

  assign instr_op = opcode_t'(instr[31:26]);
  assign funct_op = funct_t'(instr[5:0]);
  assign rs       = instr[25:21];
  assign rt       = instr[20:16];
  assign rd       = instr[15:11];

  assign commit   = instr_valid && !halted;
  assign pc_plus4 = pc + 32'd4;

  control_unit control_unit_i (
    .instr_op(instr_op), .funct_op(funct_op), .alu_op(alu_op), .halt(halt),
    .reg_dst(reg_dst), .alu_src(alu_src), .jump(jump), .branch(branch),
    .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
    .reg_write(reg_write), .ext_type(ext_type), .jal(jal)
  );

  // Immediate extension
  always_comb begin
    case (ext_type)
      EXT_ZERO:  imm_ext = {16'h0000, instr[15:0]};
      EXT_UPPER: imm_ext = {instr[15:0], 16'h0000};   // LUI
      default:   imm_ext = {{16{instr[15]}}, instr[15:0]};
    endcase
  end

  assign alu_b = alu_src ? imm_ext : rdata2;

  alu alu_i (.op(alu_op), .a(rdata1), .b(alu_b), .result(alu_result), .zero(zero));

  // Destination and write-back value
  assign waddr = jal ? `REG_ADDR_W'(`LINK_REG) : (reg_dst ? rd : rt);

  always_comb begin
    case (mem_to_reg)
      WB_MEM:  wdata = mem_read ? ram_rdata : '0;
      WB_LINK: wdata = pc_plus4;
      default: wdata = alu_result;
    endcase
  end

  register_file register_file_i (
    .CLK(CLK), .rst_n(rst_n), .we(commit && reg_write), .waddr(waddr), .wdata(wdata),
    .raddr1(rs), .raddr2(rt), .rdata1(rdata1), .rdata2(rdata2)
  );

  word_ram #(.addr_w(dmem_addr_w)) word_ram_i (
    .CLK(CLK), .rst_n(rst_n), .we(commit && mem_write),
    .addr(alu_result[dmem_addr_w+1:2]), .wdata(rdata2), .rdata(ram_rdata)
  );

  // BNE takes the branch on a nonzero difference
  assign taken = branch && ((instr_op == BNE) ? !zero : zero);

  always_comb begin
    pc_next = pc_plus4;
    if (taken) begin
      pc_next = pc_plus4 + {imm_ext[`WORD_W-3:0], 2'b00};
    end
    case (jump)
      JMP_TARGET: pc_next = {pc_plus4[`WORD_W-1:`WORD_W-4], instr[25:0], 2'b00};
      JMP_REG:    pc_next = rdata1;
      default:    ;
    endcase
  end

  // Architectural state and report strobes
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc              <= '0;
      halted          <= 1'b0;
      wb_valid        <= 1'b0;
      mem_write_valid <= 1'b0;
    end else begin
      wb_valid        <= commit && reg_write && (waddr != '0);
      mem_write_valid <= commit && mem_write;
      if (commit) begin
        if (halt) begin
          halted <= 1'b1;             // pc holds on HALT
        end else begin
          pc <= pc_next;
        end
      end
    end
  end

  // Report payload, only meaningful with its strobe
  always_ff @(posedge CLK) begin
    if (commit) begin
      wb_reg    <= waddr;
      wb_data   <= wdata;
      mem_addr  <= alu_result;
      mem_wdata <= rdata2;
    end
  end

endmodule

`default_nettype wire

// File: bench/cpu_core_tb.sv
// **********************************************************************
// Random-instruction testbench for cpu_core with a reference model.
// Register fields come from r0..r7 so values get reused.
// Inputs change on the falling edge and outputs are sampled there too.
// The run is bounded by a cycle limit derived from the test lengths.
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core_tb
  import cpu_types_pkg::*;
();

  localparam int n_alu = 200;
  localparam int n_nowr = 80;
  localparam int n_mem = 40;           // Each is ADDI, SW, LW
  localparam int n_ctrl = 100;
  localparam int n_halt = 10;
  localparam int total_instr = n_alu + n_nowr + 3 * n_mem + n_ctrl + 1 + n_halt;
  localparam int max_cycles = total_instr * 4 + 100;
  localparam int dmem_words = 1 << `DMEM_ADDR_W;

  logic        CLK, rst_n, instr_valid, wb_valid, mem_write_valid, halted;
  logic [31:0] instr, pc, wb_data, mem_addr, mem_wdata;
  logic [4:0]  wb_reg;

  logic [31:0] rng;
  int          errors, passes, cycles;

  // Architectural reference state
  logic [31:0] mregs [32];
  logic [31:0] mmem [dmem_words];
  logic [31:0] mpc;
  logic        mhalted;

  cpu_core cpu_core_i (
    .CLK(CLK), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .mem_write_valid(mem_write_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .halted(halted)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timed out after %0d cycles before all tests finished", cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  function logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function logic [4:0] rand_reg();
    logic [31:0] r;
    r = next_rand();
    return {2'b00, r[2:0]};
  endfunction

  function logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
    return {6'h00, rs, rt, rd, 5'h00, fn};
  endfunction

  function logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs, rt,
                              input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function logic [31:0] random_alu_word(input logic [4:0] dst);
    logic [31:0] r;
    logic [4:0]  rs, rt;
    logic [5:0]  code;
    int          sel;
    r = next_rand();
    rs = rand_reg();
    rt = rand_reg();
    sel = int'(r[31:16] % 20);
    case (sel)
      0: code = SLLV;
      1: code = SRLV;
      2: code = ADD;
      3: code = ADDU;
      4: code = SUB;
      5: code = SUBU;
      6: code = AND;
      7: code = OR;
      8: code = XOR;
      9: code = NOR;
      10: code = SLT;
      11: code = SLTU;
      12: code = ADDI;
      13: code = ADDIU;
      14: code = SLTI;
      15: code = SLTIU;
      16: code = ANDI;
      17: code = ORI;
      18: code = XORI;
      default: code = LUI;
    endcase
    if (sel < 12) begin
      return rtype(code, rs, rt, dst);
    end
    if (sel == 19) begin
      rs = 5'd0;                       // LUI encodes rs as zero
    end
    return itype(code, rs, dst, r[15:0]);
  endfunction

  // Half the branches compare a register with itself
  function logic [31:0] random_branch();
    logic [31:0] r;
    logic [4:0]  rs, rt;
    r = next_rand();
    rs = rand_reg();
    rt = r[0] ? rs : rand_reg();
    return itype(r[1] ? BEQ : BNE, rs, rt, {{10{r[15]}}, r[15:10]});
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end else begin
      passes++;
    end
  endtask

  task automatic model_exec(input logic [31:0] w, output logic ewb, output logic [4:0] ereg,
                            output logic [31:0] edata, output logic emw,
                            output logic [31:0] eaddr, output logic [31:0] ewdata);
    logic [5:0]  op, fn;
    logic [4:0]  rs, rt, rd, dst;
    logic [31:0] a, b, se, ze, p4, npc, res, addr;
    logic        wr;
    op = w[31:26];
    fn = w[5:0];
    rs = w[25:21];
    rt = w[20:16];
    rd = w[15:11];
    a = mregs[rs];
    b = mregs[rt];
    se = {{16{w[15]}}, w[15:0]};
    ze = {16'h0000, w[15:0]};
    p4 = mpc + 32'd4;
    npc = p4;
    res = '0;
    dst = rt;
    wr = 1'b1;
    addr = a + se;
    {ewb, ereg, edata, emw, eaddr, ewdata} = '0;
    if (!mhalted) begin
      case (op)
        RTYPE: begin
          dst = rd;
          case (fn)
            SLLV:      res = b << a[4:0];
            SRLV:      res = b >> a[4:0];
            ADD, ADDU: res = a + b;
            SUB, SUBU: res = a - b;
            AND:       res = a & b;
            OR:        res = a | b;
            XOR:       res = a ^ b;
            NOR:       res = ~(a | b);
            SLT:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      res = (a < b) ? 32'd1 : 32'd0;
            default: begin         // JR
              wr = 1'b0;
              npc = a;
            end
          endcase
        end
        ADDI, ADDIU: res = a + se;
        SLTI:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
        SLTIU: res = (a < se) ? 32'd1 : 32'd0;   // Unsigned against sign-extended imm
        ANDI:  res = a & ze;
        ORI:   res = a | ze;
        XORI:  res = a ^ ze;
        LUI:   res = {w[15:0], 16'h0000};
        LW:    res = mmem[addr[`DMEM_ADDR_W+1:2]];
        SW: begin
          wr = 1'b0;
          mmem[addr[`DMEM_ADDR_W+1:2]] = b;
          {emw, eaddr, ewdata} = {1'b1, addr, b};
        end
        BEQ, BNE: begin
          wr = 1'b0;
          if ((a == b) == (op == BEQ)) begin
            npc = p4 + {se[29:0], 2'b00};
          end
        end
        J, JAL: begin
          npc = {p4[31:28], w[25:0], 2'b00};
          wr = (op == JAL);
          dst = 5'(`LINK_REG);
          res = p4;
        end
        default: begin             // HALT
          wr = 1'b0;
          npc = mpc;
          mhalted = 1'b1;
        end
      endcase
      if (wr && (dst != 5'd0)) begin
        mregs[dst] = res;
        {ewb, ereg, edata} = {1'b1, dst, res};
      end
      mpc = npc;
    end
  endtask

  // Strobe one word, then compare the reports of the accepting edge
  task automatic issue(input logic [31:0] word);
    logic        ewb, emw;
    logic [4:0]  ereg;
    logic [31:0] edata, eaddr, ewdata;
    instr = word;
    instr_valid = 1'b1;
    model_exec(word, ewb, ereg, edata, emw, eaddr, ewdata);
    @(negedge CLK);
    instr_valid = 1'b0;
    instr = 32'h0;
    check(pc, mpc, "pc");
    check(halted, mhalted, "halted");
    check(wb_valid, ewb, "wb_valid");
    if (ewb) begin
      check(wb_reg, ereg, "wb_reg");
      check(wb_data, edata, "wb_data");
    end
    check(mem_write_valid, emw, "mem_write_valid");
    if (emw) begin
      check(mem_addr, eaddr, "mem_addr");
      check(mem_wdata, ewdata, "mem_wdata");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge CLK);
      check(wb_valid, 0, "wb_valid while idle");
      check(mem_write_valid, 0, "mem_write_valid while idle");
    end
  endtask

  task automatic step(input logic [31:0] word);
    logic [31:0] r;
    issue(word);
    r = next_rand();
    idle(int'(r % 3));
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    $display("Test %0d %s finished with %0d errors", num, name, errors - err_before);
  endtask

  initial begin
    int          err0;
    logic [31:0] w, r, hold_pc, hold_data, hold_addr, hold_wdata;
    logic [4:0]  rb, hold_reg;
    logic [15:0] off;
    rng = 32'h4bcb;
    errors = 0;
    passes = 0;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = 32'h0;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    for (int i = 0; i < dmem_words; i++) mmem[i] = '0;
    mpc = '0;
    mhalted = 1'b0;
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    err0 = errors;
    check(pc, 0, "pc after reset");
    check(halted, 0, "halted after reset");
    idle(2);
    for (int i = 0; i < n_alu; i++) step(random_alu_word(rand_reg()));
    end_test(1, "reset and ALU operations", err0);

    err0 = errors;
    for (int i = 0; i < n_nowr; i++) begin
      r = next_rand();
      case (r % 5)
        0: w = random_alu_word(5'd0);
        1: w = random_branch();
        2: w = itype(SW, rand_reg(), rand_reg(), {r[15:2], 2'b00});
        3: w = {J, r[31:6]};
        default: w = rtype(JR, rand_reg(), 5'd0, 5'd0);
      endcase
      issue(w);
      check(wb_valid, 0, "wb_valid for a non-writing instruction");
      idle(int'(r[9:8] % 3));
    end
    end_test(2, "register 0 and no-write instructions", err0);

    err0 = errors;
    for (int i = 0; i < n_mem; i++) begin
      r = next_rand();
      rb = {2'b00, r[2:0]} | 5'd1;     // Base never r0
      off = {10'h000, r[6:4], 2'b00};
      step(itype(ADDI, 5'd0, rb, {10'h000, r[10:8], 2'b00}));
      step(itype(SW, rb, rand_reg(), off));
      step(itype(LW, rb, rand_reg(), r[11] ? off : {10'h000, r[14:12], 2'b00}));
    end
    end_test(3, "loads and stores", err0);

    err0 = errors;
    for (int i = 0; i < n_ctrl; i++) begin
      r = next_rand();
      case (r % 5)
        0, 1: w = random_branch();
        2: w = {J, r[31:6]};
        3: w = {JAL, r[31:6]};
        default: w = rtype(JR, rand_reg(), 5'd0, 5'd0);
      endcase
      step(w);
    end
    end_test(4, "control flow", err0);

    err0 = errors;
    step({HALT, 26'h0});
    check(halted, 1, "halted after HALT");
    {hold_pc, hold_reg, hold_data, hold_addr, hold_wdata} =
      {pc, wb_reg, wb_data, mem_addr, mem_wdata};
    for (int i = 0; i < n_halt; i++) begin
      r = next_rand();
      w = r[0] ? random_alu_word(rand_reg()) : itype(SW, rand_reg(), rand_reg(), 16'h0004);
      step(w);
      check(pc, hold_pc, "pc while halted");
      check(wb_reg, hold_reg, "wb_reg while halted");
      check(wb_data, hold_data, "wb_data while halted");
      check(mem_addr, hold_addr, "mem_addr while halted");
      check(mem_wdata, hold_wdata, "mem_wdata while halted");
    end
    end_test(5, "halt", err0);

    $display("Checks passed: %0d, errors: %0d", passes, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/register_file.sv
hdl/word_ram.sv
hdl/cpu_core.sv
bench/cpu_core_tb.sv
